//--- build.f
+incdir+include
rtl/tlb_pkg.sv
rtl/tlb_shared_lookup.sv
rtl/tlb_translate_fsm.sv
rtl/tlb_region_top.sv
tests/tlb_region_properties.sv
tests/tlb_region_tb.sv

//--- include/tlb_settings.svh
// Single page size only; TLB_ORDER plus TLB_PG_BITS must stay below TLB_VADDR_BITS
`ifndef TLB_SETTINGS_SVH
`define TLB_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Page geometry
// ---------------------------------------------------------------------------
// Page offset width, 4 KiB pages
`define TLB_PG_BITS     12

// Number of table entries is 1 << TLB_ORDER
`define TLB_ORDER       6

// ---------------------------------------------------------------------------
// Field widths
// ---------------------------------------------------------------------------
`define TLB_VADDR_BITS  48
`define TLB_PADDR_BITS  40

// Process id, compared on every lookup
`define TLB_PID_BITS    6

// Request length, copied through untouched
`define TLB_LEN_BITS    16

`endif

//--- rtl/tlb_pkg.sv
// Shared types of the translation region; all widths follow tlb_settings.svh
`include "tlb_settings.svh"

package tlb_pkg;

    // ------------------------------------------------------------------------
    // Plain vectors
    // ------------------------------------------------------------------------
    typedef logic [`TLB_VADDR_BITS-1:0] vaddr_t;
    typedef logic [`TLB_PADDR_BITS-1:0] paddr_t;
    typedef logic [`TLB_PID_BITS-1:0] pid_t;
    typedef logic [`TLB_LEN_BITS-1:0] len_t;

    // Page numbers, offset stripped
    typedef logic [`TLB_VADDR_BITS-`TLB_PG_BITS-1:0] vpn_t;
    typedef logic [`TLB_PADDR_BITS-`TLB_PG_BITS-1:0] ppn_t;

    // Low vpn bits pick the entry, the rest is stored as tag
    typedef logic [`TLB_ORDER-1:0] index_t;
    typedef logic [`TLB_VADDR_BITS-`TLB_PG_BITS-`TLB_ORDER-1:0] tag_t;

    // ------------------------------------------------------------------------
    // Records
    // ------------------------------------------------------------------------
    typedef struct packed {
        vaddr_t vaddr;
        pid_t   pid;
        len_t   len;
    } req_t;

    typedef struct packed {
        paddr_t paddr;
        pid_t   pid;
        len_t   len;
    } xlat_t;

    typedef struct packed {
        vaddr_t vaddr;
        pid_t   pid;
    } fault_t;

    // Valid low on a map write invalidates the entry
    typedef struct packed {
        logic valid;
        vpn_t vpn;
        pid_t pid;
        ppn_t ppn;
    } map_t;

    typedef struct packed {
        vpn_t vpn;
        pid_t pid;
    } lookup_req_t;

    typedef struct packed {
        logic hit;
        ppn_t ppn;
    } lookup_rsp_t;

    // ------------------------------------------------------------------------
    // State machines
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {MTX_FREE, MTX_RD, MTX_WR} mutex_state_t;

    typedef enum logic [1:0] {ST_IDLE, ST_LOCK, ST_LOOKUP, ST_RESULT} xlat_state_t;

endpackage

//--- rtl/tlb_region_top.sv
// Read and write engines share one table; read wins lock ties, results are pulses without back-pressure
`timescale 1ns/1ps

module tlb_region_top (
    input  logic            aclk,
    input  logic            aresetn,
    input  logic            rd_req_valid,
    input  logic            wr_req_valid,
    input  tlb_pkg::req_t   rd_req,
    input  tlb_pkg::req_t   wr_req,
    output logic            rd_busy,
    output logic            wr_busy,
    output logic            rd_xlat_valid,
    output logic            wr_xlat_valid,
    output tlb_pkg::xlat_t  rd_xlat,
    output tlb_pkg::xlat_t  wr_xlat,
    output logic            rd_fault_valid,
    output logic            wr_fault_valid,
    output tlb_pkg::fault_t rd_fault,
    output tlb_pkg::fault_t wr_fault,
    input  logic            map_valid,
    input  tlb_pkg::map_t   map
);

// Lock handshake per side
logic rd_lock, wr_lock;
logic rd_grant, wr_grant;

// Lookup path
logic                 rd_lookup_valid, wr_lookup_valid;
tlb_pkg::lookup_req_t rd_lookup_req, wr_lookup_req;
tlb_pkg::lookup_rsp_t lookup_rsp;

// ---------------------------------------------------------------------------
// Engines
// ---------------------------------------------------------------------------
tlb_translate_fsm inst_fsm_rd (
    .aclk(aclk),
    .aresetn(aresetn),
    .req_valid(rd_req_valid),
    .req(rd_req),
    .busy(rd_busy),
    .lock(rd_lock),
    .grant(rd_grant),
    .lookup_valid(rd_lookup_valid),
    .lookup_req(rd_lookup_req),
    .lookup_rsp(lookup_rsp),
    .xlat_valid(rd_xlat_valid),
    .xlat(rd_xlat),
    .fault_valid(rd_fault_valid),
    .fault(rd_fault)
);

tlb_translate_fsm inst_fsm_wr (
    .aclk(aclk),
    .aresetn(aresetn),
    .req_valid(wr_req_valid),
    .req(wr_req),
    .busy(wr_busy),
    .lock(wr_lock),
    .grant(wr_grant),
    .lookup_valid(wr_lookup_valid),
    .lookup_req(wr_lookup_req),
    .lookup_rsp(lookup_rsp),
    .xlat_valid(wr_xlat_valid),
    .xlat(wr_xlat),
    .fault_valid(wr_fault_valid),
    .fault(wr_fault)
);

// ---------------------------------------------------------------------------
// Shared table and mutex
// ---------------------------------------------------------------------------
// Both engines see the same response, only the granted one reads it
tlb_shared_lookup inst_lookup (
    .aclk(aclk),
    .aresetn(aresetn),
    .rd_lock(rd_lock),
    .wr_lock(wr_lock),
    .rd_grant(rd_grant),
    .wr_grant(wr_grant),
    .rd_lookup_valid(rd_lookup_valid),
    .wr_lookup_valid(wr_lookup_valid),
    .rd_lookup_req(rd_lookup_req),
    .wr_lookup_req(wr_lookup_req),
    .lookup_rsp(lookup_rsp),
    .map_valid(map_valid),
    .map(map)
);

endmodule

//--- rtl/tlb_shared_lookup.sv
// Direct-mapped, one read port; a map write in the lookup cycle is seen only by later lookups
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_shared_lookup (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 rd_lock,
    input  logic                 wr_lock,
    output logic                 rd_grant,
    output logic                 wr_grant,
    input  logic                 rd_lookup_valid,
    input  logic                 wr_lookup_valid,
    input  tlb_pkg::lookup_req_t rd_lookup_req,
    input  tlb_pkg::lookup_req_t wr_lookup_req,
    output tlb_pkg::lookup_rsp_t lookup_rsp,
    input  logic                 map_valid,
    input  tlb_pkg::map_t        map
);

localparam int N_ENTRIES = 1 << `TLB_ORDER;

tlb_pkg::mutex_state_t mtx_state;

// Lookup port after the grant mux
logic                 lkp_valid;
tlb_pkg::lookup_req_t lkp_req;
tlb_pkg::index_t      lkp_idx;
tlb_pkg::tag_t        lkp_tag;
logic                 lkp_hit;

// Map port
tlb_pkg::index_t map_idx;
tlb_pkg::tag_t   map_tag;

// Entry storage, valid bits carry the reset
logic [N_ENTRIES-1:0] valid_q;
tlb_pkg::tag_t        tag_mem [N_ENTRIES];
tlb_pkg::pid_t        pid_mem [N_ENTRIES];
tlb_pkg::ppn_t        ppn_mem [N_ENTRIES];

tlb_pkg::lookup_rsp_t rsp_q;

// ---------------------------------------------------------------------------
// Mutex
// ---------------------------------------------------------------------------
always_ff @(posedge aclk) begin
    if (!aresetn) begin
        mtx_state <= tlb_pkg::MTX_FREE;
    end else begin
        case (mtx_state)
            tlb_pkg::MTX_FREE: begin
                // Read wins a tie
                if (rd_lock) begin
                    mtx_state <= tlb_pkg::MTX_RD;
                end else if (wr_lock) begin
                    mtx_state <= tlb_pkg::MTX_WR;
                end
            end
            tlb_pkg::MTX_RD: begin
                if (!rd_lock) begin
                    mtx_state <= tlb_pkg::MTX_FREE;
                end
            end
            tlb_pkg::MTX_WR: begin
                if (!wr_lock) begin
                    mtx_state <= tlb_pkg::MTX_FREE;
                end
            end
            default: mtx_state <= tlb_pkg::MTX_FREE;
        endcase
    end
end

assign rd_grant = (mtx_state == tlb_pkg::MTX_RD);
assign wr_grant = (mtx_state == tlb_pkg::MTX_WR);

// ---------------------------------------------------------------------------
// Lookup mux and compare
// ---------------------------------------------------------------------------
// Strobes from a non-granted engine are dropped
assign lkp_valid = (rd_grant && rd_lookup_valid) || (wr_grant && wr_lookup_valid);
assign lkp_req   = wr_grant ? wr_lookup_req : rd_lookup_req;

assign lkp_idx = lkp_req.vpn[`TLB_ORDER-1:0];
assign lkp_tag = lkp_req.vpn[$bits(tlb_pkg::vpn_t)-1:`TLB_ORDER];

// Hit needs valid, tag and pid all matching
assign lkp_hit = valid_q[lkp_idx] && (tag_mem[lkp_idx] == lkp_tag) &&
                 (pid_mem[lkp_idx] == lkp_req.pid);

// Response held until the next lookup
always_ff @(posedge aclk) begin
    if (lkp_valid) begin
        rsp_q.hit <= lkp_hit;
        rsp_q.ppn <= ppn_mem[lkp_idx];
    end
end

assign lookup_rsp = rsp_q;

// ---------------------------------------------------------------------------
// Map port
// ---------------------------------------------------------------------------
assign map_idx = map.vpn[`TLB_ORDER-1:0];
assign map_tag = map.vpn[$bits(tlb_pkg::vpn_t)-1:`TLB_ORDER];

always_ff @(posedge aclk) begin
    if (!aresetn) begin
        valid_q <= '0;
    end else if (map_valid) begin
        valid_q[map_idx] <= map.valid;
    end
end

always_ff @(posedge aclk) begin
    if (map_valid) begin
        tag_mem[map_idx] <= map_tag;
        pid_mem[map_idx] <= map.pid;
        ppn_mem[map_idx] <= map.ppn;
    end
end

endmodule

//--- rtl/tlb_translate_fsm.sv
// One request in flight; a new strobe is accepted in idle or in the result cycle only
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_translate_fsm (
    input  logic                 aclk,
    input  logic                 aresetn,
    input  logic                 req_valid,
    input  tlb_pkg::req_t        req,
    output logic                 busy,
    output logic                 lock,
    input  logic                 grant,
    output logic                 lookup_valid,
    output tlb_pkg::lookup_req_t lookup_req,
    input  tlb_pkg::lookup_rsp_t lookup_rsp,
    output logic                 xlat_valid,
    output tlb_pkg::xlat_t       xlat,
    output logic                 fault_valid,
    output tlb_pkg::fault_t      fault
);

tlb_pkg::xlat_state_t state;

// Stored request, payload only
tlb_pkg::req_t req_q;

// Page offset of the stored request
logic [`TLB_PG_BITS-1:0] pg_offs;

logic in_result;

// ---------------------------------------------------------------------------
// State machine
// ---------------------------------------------------------------------------
always_ff @(posedge aclk) begin
    if (!aresetn) begin
        state <= tlb_pkg::ST_IDLE;
    end else begin
        case (state)
            tlb_pkg::ST_IDLE: begin
                if (req_valid) begin
                    state <= tlb_pkg::ST_LOCK;
                end
            end
            tlb_pkg::ST_LOCK: begin
                // Wait here while the other side owns the table
                if (grant) begin
                    state <= tlb_pkg::ST_LOOKUP;
                end
            end
            tlb_pkg::ST_LOOKUP: begin
                state <= tlb_pkg::ST_RESULT;
            end
            tlb_pkg::ST_RESULT: begin
                // Busy is already low here, so back-to-back requests land now
                if (req_valid) begin
                    state <= tlb_pkg::ST_LOCK;
                end else begin
                    state <= tlb_pkg::ST_IDLE;
                end
            end
            default: state <= tlb_pkg::ST_IDLE;
        endcase
    end
end

// Capture on acceptance
always_ff @(posedge aclk) begin
    if (req_valid && !busy) begin
        req_q <= req;
    end
end

// ---------------------------------------------------------------------------
// Lock and lookup
// ---------------------------------------------------------------------------
// Lock covers the wait and the lookup, released in the result cycle
assign lock = (state == tlb_pkg::ST_LOCK) || (state == tlb_pkg::ST_LOOKUP);
assign busy = lock;

// Single strobe, grant is always held in this state
assign lookup_valid   = (state == tlb_pkg::ST_LOOKUP);
assign lookup_req.vpn = req_q.vaddr[`TLB_VADDR_BITS-1:`TLB_PG_BITS];
assign lookup_req.pid = req_q.pid;

// ---------------------------------------------------------------------------
// Result
// ---------------------------------------------------------------------------
assign in_result = (state == tlb_pkg::ST_RESULT);
assign pg_offs   = req_q.vaddr[`TLB_PG_BITS-1:0];

// Exactly one of the two pulses per request
assign xlat_valid  = in_result && lookup_rsp.hit;
assign fault_valid = in_result && !lookup_rsp.hit;

// Translated address is ppn with the original offset
assign xlat.paddr = {lookup_rsp.ppn, pg_offs};
assign xlat.pid   = req_q.pid;
assign xlat.len   = req_q.len;

// Fault reports the untranslated address
assign fault.vaddr = req_q.vaddr;
assign fault.pid   = req_q.pid;

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the translation region testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f build.f \
    --top-module tlb_region_tb \
    -o Vtlb_region_tb

status=0
./obj_dir/Vtlb_region_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit "$status"

//--- tests/tlb_region_properties.sv
// Grant may outlast its lock by one cycle, the release edge; checks are off during reset
`timescale 1ns/1ps

module tlb_region_properties (
    input logic aclk,
    input logic aresetn,
    input logic rd_lock,
    input logic wr_lock,
    input logic rd_grant,
    input logic wr_grant,
    input logic rd_xlat_valid,
    input logic rd_fault_valid,
    input logic wr_xlat_valid,
    input logic wr_fault_valid
);

// ---------------------------------------------------------------------------
// Mutex
// ---------------------------------------------------------------------------
grants_exclusive: assert property (@(posedge aclk) disable iff (!aresetn)
    !(rd_grant && wr_grant)) else $error("Read and write grants high together");

// Grant only follows a lock held in the cycle before
rd_grant_locked: assert property (@(posedge aclk) disable iff (!aresetn)
    rd_grant |-> $past(rd_lock)) else $error("Read grant without read lock");

wr_grant_locked: assert property (@(posedge aclk) disable iff (!aresetn)
    wr_grant |-> $past(wr_lock)) else $error("Write grant without write lock");

// ---------------------------------------------------------------------------
// Result pulses
// ---------------------------------------------------------------------------
rd_one_result: assert property (@(posedge aclk) disable iff (!aresetn)
    !(rd_xlat_valid && rd_fault_valid)) else $error("Read xlat and fault together");

wr_one_result: assert property (@(posedge aclk) disable iff (!aresetn)
    !(wr_xlat_valid && wr_fault_valid)) else $error("Write xlat and fault together");

endmodule

bind tlb_region_top tlb_region_properties props (
    .aclk(aclk),
    .aresetn(aresetn),
    .rd_lock(rd_lock),
    .wr_lock(wr_lock),
    .rd_grant(rd_grant),
    .wr_grant(wr_grant),
    .rd_xlat_valid(rd_xlat_valid),
    .rd_fault_valid(rd_fault_valid),
    .wr_xlat_valid(wr_xlat_valid),
    .wr_fault_valid(wr_fault_valid)
);

//--- tests/tlb_region_tb.sv
// Maps change only while both engines are idle, so each expected result is fixed at issue time
`timescale 1ns/1ps
`include "tlb_settings.svh"

module tlb_region_tb;

localparam int N_ENTRIES  = 1 << `TLB_ORDER;
localparam int N_DIRECTED = 12;
localparam int N_STEPS    = 300;
// At most one request per side in each random step
localparam int N_REQUESTS      = N_DIRECTED + 2 * N_STEPS;
localparam int SETUP_CYCLES    = 50;
localparam int WATCHDOG_CYCLES = N_REQUESTS * 20 + SETUP_CYCLES;

// Expected outcome; is_xlat picks which record counts
typedef struct packed {
    logic            is_xlat;
    tlb_pkg::xlat_t  xlat;
    tlb_pkg::fault_t fault;
} expect_t;

logic            aclk = 1'b0;
logic            aresetn;
logic            rd_req_valid;
logic            wr_req_valid;
tlb_pkg::req_t   rd_req;
tlb_pkg::req_t   wr_req;
logic            rd_busy;
logic            wr_busy;
logic            rd_xlat_valid;
logic            wr_xlat_valid;
tlb_pkg::xlat_t  rd_xlat;
tlb_pkg::xlat_t  wr_xlat;
logic            rd_fault_valid;
logic            wr_fault_valid;
tlb_pkg::fault_t rd_fault;
tlb_pkg::fault_t wr_fault;
logic            map_valid;
tlb_pkg::map_t   map;

// Shadow of the table, same indexing as the DUT
tlb_pkg::map_t shadow [N_ENTRIES];

// Pending expectations, in issue order per side
expect_t rd_exp [$];
expect_t wr_exp [$];
expect_t rd_next;
expect_t wr_next;

integer seed = 19;
int     value_errors = 0;
int     kind_errors = 0;
int     stray_errors = 0;

always #4 aclk = ~aclk;

tlb_region_top uut (
    .aclk(aclk),
    .aresetn(aresetn),
    .rd_req_valid(rd_req_valid),
    .wr_req_valid(wr_req_valid),
    .rd_req(rd_req),
    .wr_req(wr_req),
    .rd_busy(rd_busy),
    .wr_busy(wr_busy),
    .rd_xlat_valid(rd_xlat_valid),
    .wr_xlat_valid(wr_xlat_valid),
    .rd_xlat(rd_xlat),
    .wr_xlat(wr_xlat),
    .rd_fault_valid(rd_fault_valid),
    .wr_fault_valid(wr_fault_valid),
    .rd_fault(rd_fault),
    .wr_fault(wr_fault),
    .map_valid(map_valid),
    .map(map)
);

// ---------------------------------------------------------------------------
// Reference model
// ---------------------------------------------------------------------------
// Hit needs valid, full vpn and pid equal; paddr is ppn plus offset
function automatic expect_t expect_result(input tlb_pkg::req_t r);
    tlb_pkg::vpn_t   vpn;
    tlb_pkg::index_t idx;
    tlb_pkg::map_t   e;
    expect_t         res;
    vpn = r.vaddr[`TLB_VADDR_BITS-1:`TLB_PG_BITS];
    idx = vpn[`TLB_ORDER-1:0];
    e = shadow[idx];
    res = '0;
    res.is_xlat = e.valid && (e.vpn == vpn) && (e.pid == r.pid);
    res.xlat.paddr = {e.ppn, r.vaddr[`TLB_PG_BITS-1:0]};
    res.xlat.pid = r.pid;
    res.xlat.len = r.len;
    res.fault.vaddr = r.vaddr;
    res.fault.pid = r.pid;
    return res;
endfunction

function automatic tlb_pkg::req_t build_req(input tlb_pkg::tag_t tag,
                                            input tlb_pkg::index_t idx,
                                            input logic [`TLB_PG_BITS-1:0] offs,
                                            input tlb_pkg::pid_t pid,
                                            input tlb_pkg::len_t len);
    tlb_pkg::req_t r;
    r.vaddr = {tag, idx, offs};
    r.pid = pid;
    r.len = len;
    return r;
endfunction

function automatic logic [31:0] draw_random();
    return $random(seed);
endfunction

// Small tag, pid and index ranges so random traffic hits often
function automatic tlb_pkg::req_t random_req();
    logic [31:0] a;
    logic [31:0] b;
    a = draw_random();
    b = draw_random();
    return build_req(tlb_pkg::tag_t'(a[1:0]), tlb_pkg::index_t'(a[4:2]), a[16:5],
                     tlb_pkg::pid_t'(a[18:17]), b[15:0]);
endfunction

// ---------------------------------------------------------------------------
// Compare tasks
// ---------------------------------------------------------------------------
task automatic check_xlat(input string side, input tlb_pkg::xlat_t got,
                          input tlb_pkg::xlat_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED t=%0t: %s xlat paddr=%h pid=%h len=%h, expected %h %h %h",
                 $time, side, got.paddr, got.pid, got.len, exp.paddr, exp.pid, exp.len);
    end
endtask

task automatic check_fault(input string side, input tlb_pkg::fault_t got,
                           input tlb_pkg::fault_t exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED t=%0t: %s fault vaddr=%h pid=%h, expected %h %h",
                 $time, side, got.vaddr, got.pid, exp.vaddr, exp.pid);
    end
endtask

task automatic check_busy(input string side, input logic got, input logic exp);
    if (got !== exp) begin
        value_errors++;
        $display("CHECK FAILED t=%0t: %s busy=%b, expected %b", $time, side, got, exp);
    end
endtask

task automatic judge_result(input string side, input logic got_xlat,
                            input tlb_pkg::xlat_t x, input tlb_pkg::fault_t f,
                            input expect_t e);
    if (got_xlat != e.is_xlat) begin
        kind_errors++;
        $display("The %s engine gave a %s where a %s was expected, at time %0t", side,
                 got_xlat ? "translation" : "page fault",
                 e.is_xlat ? "translation" : "page fault", $time);
    end else if (got_xlat) begin
        check_xlat(side, x, e.xlat);
    end else begin
        check_fault(side, f, e.fault);
    end
endtask

// Result pulses sampled before the edge updates them
always @(posedge aclk) begin
    if (aresetn) begin
        // Busy from the cycle after acceptance up to the result pulse
        check_busy("read", rd_busy, !(rd_xlat_valid || rd_fault_valid) &&
                   (rd_exp.size() > (rd_req_valid ? 1 : 0)));
        check_busy("write", wr_busy, !(wr_xlat_valid || wr_fault_valid) &&
                   (wr_exp.size() > (wr_req_valid ? 1 : 0)));
        if (rd_xlat_valid || rd_fault_valid) begin
            if (rd_exp.size() == 0) begin
                stray_errors++;
                $display("The read engine gave a result with no request pending, at %0t", $time);
            end else begin
                rd_next = rd_exp.pop_front();
                judge_result("read", rd_xlat_valid, rd_xlat, rd_fault, rd_next);
            end
        end
        if (wr_xlat_valid || wr_fault_valid) begin
            if (wr_exp.size() == 0) begin
                stray_errors++;
                $display("The write engine gave a result with no request pending, at %0t", $time);
            end else begin
                wr_next = wr_exp.pop_front();
                judge_result("write", wr_xlat_valid, wr_xlat, wr_fault, wr_next);
            end
        end
    end
end

// ---------------------------------------------------------------------------
// Stimulus tasks, each starts and ends on a falling edge
// ---------------------------------------------------------------------------
task automatic program_entry(input tlb_pkg::tag_t tag, input tlb_pkg::index_t idx,
                             input tlb_pkg::pid_t pid, input tlb_pkg::ppn_t ppn,
                             input logic valid);
    tlb_pkg::map_t m;
    // No lookup may be in flight
    while (rd_busy || wr_busy) begin
        @(negedge aclk);
    end
    m.valid = valid;
    m.vpn = {tag, idx};
    m.pid = pid;
    m.ppn = ppn;
    map_valid = 1'b1;
    map = m;
    shadow[idx] = m;
    @(negedge aclk);
    map_valid = 1'b0;
endtask

task automatic send_requests(input logic do_rd, input tlb_pkg::req_t rq,
                             input logic do_wr, input tlb_pkg::req_t wq);
    while ((do_rd && rd_busy) || (do_wr && wr_busy)) begin
        @(negedge aclk);
    end
    rd_req_valid = do_rd;
    wr_req_valid = do_wr;
    rd_req = rq;
    wr_req = wq;
    if (do_rd) begin
        rd_exp.push_back(expect_result(rq));
    end
    if (do_wr) begin
        wr_exp.push_back(expect_result(wq));
    end
    @(negedge aclk);
    rd_req_valid = 1'b0;
    wr_req_valid = 1'b0;
endtask

// ---------------------------------------------------------------------------
// Main sequence
// ---------------------------------------------------------------------------
initial begin
    logic [31:0]   rnd;
    logic [31:0]   rnd2;
    tlb_pkg::req_t hit_a;
    int            step;
    aresetn = 1'b0;
    rd_req_valid = 1'b0;
    wr_req_valid = 1'b0;
    rd_req = '0;
    wr_req = '0;
    map_valid = 1'b0;
    map = '0;
    for (int i = 0; i < N_ENTRIES; i++) begin
        shadow[i] = '0;
    end
    repeat (3) @(negedge aclk);
    aresetn = 1'b1;
    @(negedge aclk);

    // Map, then hit from both sides
    program_entry(30'd5, 6'd3, 6'd2, 28'h1234567, 1'b1);
    hit_a = build_req(30'd5, 6'd3, 12'habc, 6'd2, 16'd64);
    send_requests(1'b1, hit_a, 1'b0, '0);
    send_requests(1'b0, '0, 1'b1, build_req(30'd5, 6'd3, 12'h004, 6'd2, 16'd4096));

    // Unmapped index, wrong pid, wrong tag
    send_requests(1'b1, build_req(30'd5, 6'd10, 12'h100, 6'd2, 16'd8), 1'b0, '0);
    send_requests(1'b1, build_req(30'd5, 6'd3, 12'h100, 6'd3, 16'd8), 1'b0, '0);
    send_requests(1'b0, '0, 1'b1, build_req(30'd6, 6'd3, 12'h100, 6'd2, 16'd8));

    // Same-cycle strobes, write waits for the read to release
    send_requests(1'b1, hit_a, 1'b1, build_req(30'd1, 6'd20, 12'h0ff, 6'd1, 16'd2));
    send_requests(1'b1, hit_a, 1'b1, build_req(30'd5, 6'd3, 12'hfff, 6'd2, 16'd1));

    // Remap to a new ppn, then invalidate
    program_entry(30'd5, 6'd3, 6'd2, 28'h00abcde, 1'b1);
    send_requests(1'b1, hit_a, 1'b0, '0);
    program_entry(30'd5, 6'd3, 6'd2, 28'h00abcde, 1'b0);
    send_requests(1'b0, '0, 1'b1, hit_a);

    // Random mix, maps only while both sides are idle
    for (step = 0; step < N_STEPS; step++) begin
        rnd = draw_random();
        if (!rd_busy && !wr_busy && rnd[1:0] == 2'd0) begin
            rnd2 = draw_random();
            program_entry(tlb_pkg::tag_t'(rnd[5:4]), tlb_pkg::index_t'(rnd[8:6]),
                          tlb_pkg::pid_t'(rnd[10:9]), rnd2[27:0], rnd[31:30] != 2'd0);
        end else begin
            if (!rd_busy && rnd[2]) begin
                rd_req_valid = 1'b1;
                rd_req = random_req();
                rd_exp.push_back(expect_result(rd_req));
            end
            if (!wr_busy && rnd[3]) begin
                wr_req_valid = 1'b1;
                wr_req = random_req();
                wr_exp.push_back(expect_result(wr_req));
            end
            @(negedge aclk);
            rd_req_valid = 1'b0;
            wr_req_valid = 1'b0;
        end
    end

    // Drain, then a few idle cycles to catch stray pulses
    while (rd_exp.size() != 0 || wr_exp.size() != 0) begin
        @(negedge aclk);
    end
    repeat (4) @(negedge aclk);

    $display("Errors: %0d wrong value, %0d wrong kind, %0d unexpected result",
             value_errors, kind_errors, stray_errors);
    if (value_errors + kind_errors + stray_errors == 0) begin
        $display("Simulation completed successfully");
    end else begin
        $display("Simulation failed");
    end
    $finish;
end

// ---------------------------------------------------------------------------
// Watchdog
// ---------------------------------------------------------------------------
initial begin
    repeat (WATCHDOG_CYCLES) @(posedge aclk);
    $display("Timeout after %0d cycles, %0d read and %0d write results never arrived",
             WATCHDOG_CYCLES, rd_exp.size(), wr_exp.size());
    $display("Simulation failed");
    $finish;
end

endmodule
